//--- hw/chess_pkg.sv
package chess_pkg;

   localparam int SQUARE_W    = 4;
   localparam int NUM_SQUARES = 64;
   localparam int BOARD_W     = SQUARE_W * NUM_SQUARES;
   localparam int SQ_IDX_W    = 6;

   // piece kinds, the black flag sits above them
   localparam logic [2:0] KIND_EMPTY  = 3'd0;
   localparam logic [2:0] KIND_PAWN   = 3'd1;
   localparam logic [2:0] KIND_KNIGHT = 3'd2;
   localparam logic [2:0] KIND_BISHOP = 3'd3;
   localparam logic [2:0] KIND_ROOK   = 3'd4;
   localparam logic [2:0] KIND_QUEEN  = 3'd5;
   localparam logic [2:0] KIND_KING   = 3'd6;

   localparam int MAX_MOVES  = 256;
   localparam int MOVE_IDX_W = 8;
   localparam int MOVE_CNT_W = 9;

   // square walker states
   localparam int WALK_STATE_W = 4;

   localparam logic [WALK_STATE_W-1:0] WALK_IDLE      = 4'd0;
   localparam logic [WALK_STATE_W-1:0] WALK_SCAN      = 4'd1;
   localparam logic [WALK_STATE_W-1:0] WALK_DIR_INIT  = 4'd2;
   localparam logic [WALK_STATE_W-1:0] WALK_STEP      = 4'd3;
   localparam logic [WALK_STATE_W-1:0] WALK_PAWN_WAIT = 4'd4;
   localparam logic [WALK_STATE_W-1:0] WALK_PAWN      = 4'd5;
   localparam logic [WALK_STATE_W-1:0] WALK_NEXT      = 4'd6;
   localparam logic [WALK_STATE_W-1:0] WALK_DRAIN     = 4'd7;
   localparam logic [WALK_STATE_W-1:0] WALK_DONE      = 4'd8;

   // one square code, seen raw or as color plus kind
   typedef union packed {
      logic [SQUARE_W-1:0] code;
      struct packed {
         logic       black;
         logic [2:0] kind;
      } piece;
   } square_u;

   // square s = row*8 + col sits at bits s*4 and up
   typedef square_u [NUM_SQUARES-1:0] board_t;

endpackage

//--- hw/step_table.sv
`timescale 1ns/100ps

module step_table
   (
      input  logic [2:0]        kind,
      input  logic [2:0]        dir_index,
      output logic signed [2:0] d_row,
      output logic signed [2:0] d_col,
      output logic [3:0]        dir_count,
      output logic              is_slider
   );

   logic [2:0] line_sel;
   logic [5:0] line_step;
   logic [5:0] jump_step;

   always_comb
   begin
      line_sel  = dir_index;
      dir_count = 4'd0;
      is_slider = 1'b0;
      case (kind)
         chess_pkg::KIND_ROOK:
         begin
            line_sel  = {1'b0, dir_index[1:0]}; // orthogonal half
            dir_count = 4'd4;
            is_slider = 1'b1;
         end
         chess_pkg::KIND_BISHOP:
         begin
            line_sel  = {1'b1, dir_index[1:0]}; // diagonal half
            dir_count = 4'd4;
            is_slider = 1'b1;
         end
         chess_pkg::KIND_QUEEN:
         begin
            dir_count = 4'd8;
            is_slider = 1'b1;
         end
         chess_pkg::KIND_KNIGHT, chess_pkg::KIND_KING:
            dir_count = 4'd8;
         chess_pkg::KIND_EMPTY, chess_pkg::KIND_PAWN:
            dir_count = 4'd0; // pawns go through pawn_targets
         default:
            dir_count = 4'd0;
      endcase
   end

   always_comb
   begin
      case (line_sel)
         3'd0: line_step = {3'sd1, 3'sd0};
         3'd1: line_step = {-3'sd1, 3'sd0};
         3'd2: line_step = {3'sd0, 3'sd1};
         3'd3: line_step = {3'sd0, -3'sd1};
         3'd4: line_step = {3'sd1, 3'sd1};
         3'd5: line_step = {3'sd1, -3'sd1};
         3'd6: line_step = {-3'sd1, 3'sd1};
         default: line_step = {-3'sd1, -3'sd1};
      endcase
      case (dir_index)
         3'd0: jump_step = {-3'sd2, -3'sd1};
         3'd1: jump_step = {-3'sd1, -3'sd2};
         3'd2: jump_step = {3'sd1, -3'sd2};
         3'd3: jump_step = {3'sd2, -3'sd1};
         3'd4: jump_step = {3'sd2, 3'sd1};
         3'd5: jump_step = {3'sd1, 3'sd2};
         3'd6: jump_step = {-3'sd1, 3'sd2};
         default: jump_step = {-3'sd2, 3'sd1};
      endcase
   end

   assign {d_row, d_col} = (kind == chess_pkg::KIND_KNIGHT) ? jump_step : line_step;

endmodule

//--- hw/pawn_targets.sv
`timescale 1ns/100ps

module pawn_targets
   (
      input  logic                                clk,
      input  chess_pkg::board_t                   board,
      input  logic                                white_to_move,
      input  logic [2:0]                          origin_row,
      input  logic [2:0]                          origin_col,
      output logic [3:0][chess_pkg::SQ_IDX_W-1:0] pawn_to,
      output logic [3:0]                          pawn_ok
   );

   logic [4:0]         fwd_row;
   logic [4:0]         dbl_row;
   logic [2:0]         start_row;
   logic [2:0]         left_col;
   logic [2:0]         right_col;
   logic               fwd_on;
   chess_pkg::square_u fwd_sq;
   chess_pkg::square_u dbl_sq;
   chess_pkg::square_u left_sq;
   chess_pkg::square_u right_sq;

   always_comb
   begin
      fwd_row   = {2'b00, origin_row} + (white_to_move ? 5'd1 : 5'b11111);
      dbl_row   = {2'b00, origin_row} + (white_to_move ? 5'd2 : 5'b11110);
      start_row = white_to_move ? 3'd1 : 3'd6;
      left_col  = origin_col - 3'd1; // wraps at col 0, masked below
      right_col = origin_col + 3'd1;
      fwd_on    = fwd_row[4:3] == 2'b00;
      fwd_sq    = board[{fwd_row[2:0], origin_col}];
      dbl_sq    = board[{dbl_row[2:0], origin_col}];
      left_sq   = board[{fwd_row[2:0], left_col}];
      right_sq  = board[{fwd_row[2:0], right_col}];
   end

   // free running, only looked at in the pawn states
   always_ff @(posedge clk)
   begin
      pawn_to[0] <= {fwd_row[2:0], origin_col};
      pawn_to[1] <= {dbl_row[2:0], origin_col};
      pawn_to[2] <= {fwd_row[2:0], left_col};
      pawn_to[3] <= {fwd_row[2:0], right_col};

      pawn_ok[0] <= fwd_on && fwd_sq.code == '0;
      pawn_ok[1] <= origin_row == start_row && fwd_sq.code == '0 && dbl_sq.code == '0;
      pawn_ok[2] <= fwd_on && origin_col != 3'd0 && left_sq.code != '0 &&
                    left_sq.piece.black == white_to_move; // enemy only
      pawn_ok[3] <= fwd_on && origin_col != 3'd7 && right_sq.code != '0 &&
                    right_sq.piece.black == white_to_move;
   end

endmodule

//--- hw/square_walker.sv
`timescale 1ns/100ps

module square_walker
   (
      input  logic                                clk,
      input  logic                                reset,
      input  logic                                board_valid,
      input  chess_pkg::board_t                   board_in,
      input  logic                                white_to_move_in,
      input  logic                                clear_moves,
      output logic [2:0]                          kind,
      output logic [2:0]                          dir_index,
      input  logic signed [2:0]                   d_row,
      input  logic signed [2:0]                   d_col,
      input  logic [3:0]                          dir_count,
      input  logic                                is_slider,
      output logic [2:0]                          origin_row,
      output logic [2:0]                          origin_col,
      input  logic [3:0][chess_pkg::SQ_IDX_W-1:0] pawn_to,
      input  logic [3:0]                          pawn_ok,
      output chess_pkg::board_t                   board,
      output logic                                white_to_move,
      output logic                                emit,
      output logic                                start,
      output logic [chess_pkg::SQ_IDX_W-1:0]      from_sq,
      output logic [chess_pkg::SQ_IDX_W-1:0]      to_sq,
      output logic                                moves_ready
   );

   logic [chess_pkg::WALK_STATE_W-1:0] state;
   logic [chess_pkg::SQ_IDX_W-1:0]     sq;
   logic [3:0]                         dir_cnt;
   logic [1:0]                         pawn_idx;
   logic signed [4:0]                  cur_row;
   logic signed [4:0]                  cur_col;
   chess_pkg::square_u                 here;
   chess_pkg::square_u                 tgt;
   logic                               here_own;
   logic                               tgt_on_board;
   logic                               tgt_empty;
   logic                               tgt_own;
   logic [2:0]                         pawn_stop_row;

   assign here       = board[sq];
   assign kind       = here.piece.kind;
   assign dir_index  = dir_cnt[2:0];
   assign origin_row = sq[5:3];
   assign origin_col = sq[2:0];

   assign tgt          = board[{cur_row[2:0], cur_col[2:0]}];
   assign tgt_on_board = cur_row[4:3] == 2'b00 && cur_col[4:3] == 2'b00;
   assign tgt_empty    = tgt.code == '0;
   assign tgt_own      = !tgt_empty && tgt.piece.black == !white_to_move;
   assign here_own     = here.code != '0 && here.piece.black == !white_to_move;

   // a pawn here would promote, so it is skipped
   assign pawn_stop_row = white_to_move ? 3'd6 : 3'd1;

   always_ff @(posedge clk)
   begin
      if (state == chess_pkg::WALK_IDLE && board_valid)
      begin
         board         <= board_in;
         white_to_move <= white_to_move_in;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= chess_pkg::WALK_IDLE;
         emit        <= 1'b0;
         start       <= 1'b0;
         moves_ready <= 1'b0;
      end
      else
      begin
         emit  <= 1'b0;
         start <= 1'b0;
         case (state)
            chess_pkg::WALK_IDLE:
               if (board_valid)
               begin
                  start <= 1'b1; // clears the write address
                  sq    <= '0;
                  state <= chess_pkg::WALK_SCAN;
               end
            chess_pkg::WALK_SCAN:
            begin
               dir_cnt  <= '0;
               pawn_idx <= '0;
               if (!here_own)
                  state <= chess_pkg::WALK_NEXT;
               else if (kind == chess_pkg::KIND_PAWN)
                  state <= (origin_row == pawn_stop_row) ? chess_pkg::WALK_NEXT
                                                         : chess_pkg::WALK_PAWN_WAIT;
               else
                  state <= chess_pkg::WALK_DIR_INIT;
            end
            chess_pkg::WALK_DIR_INIT:
               if (dir_cnt < dir_count)
               begin
                  cur_row <= $signed({2'b00, origin_row}) + d_row;
                  cur_col <= $signed({2'b00, origin_col}) + d_col;
                  state   <= chess_pkg::WALK_STEP;
               end
               else
                  state <= chess_pkg::WALK_NEXT;
            chess_pkg::WALK_STEP:
            begin
               if (tgt_on_board && !tgt_own)
               begin
                  emit    <= 1'b1;
                  from_sq <= sq;
                  to_sq   <= {cur_row[2:0], cur_col[2:0]};
               end
               if (tgt_on_board && tgt_empty && is_slider)
               begin
                  cur_row <= cur_row + d_row; // keep sliding
                  cur_col <= cur_col + d_col;
               end
               else
               begin
                  dir_cnt <= dir_cnt + 4'd1;
                  state   <= chess_pkg::WALK_DIR_INIT;
               end
            end
            chess_pkg::WALK_PAWN_WAIT:
               state <= chess_pkg::WALK_PAWN; // pawn_targets settles
            chess_pkg::WALK_PAWN:
            begin
               if (pawn_ok[pawn_idx])
               begin
                  emit    <= 1'b1;
                  from_sq <= sq;
                  to_sq   <= pawn_to[pawn_idx];
               end
               pawn_idx <= pawn_idx + 2'd1;
               if (pawn_idx == 2'd3)
                  state <= chess_pkg::WALK_NEXT;
            end
            chess_pkg::WALK_NEXT:
               if (sq == '1)
                  state <= chess_pkg::WALK_DRAIN;
               else
               begin
                  sq    <= sq + 1'b1;
                  state <= chess_pkg::WALK_SCAN;
               end
            chess_pkg::WALK_DRAIN:
            begin
               moves_ready <= 1'b1; // last RAM write lands this cycle
               state       <= chess_pkg::WALK_DONE;
            end
            chess_pkg::WALK_DONE:
               if (clear_moves)
               begin
                  moves_ready <= 1'b0;
                  state       <= chess_pkg::WALK_IDLE;
               end
            default:
               state <= chess_pkg::WALK_IDLE;
         endcase
      end
   end

endmodule

//--- hw/move_store.sv
`timescale 1ns/100ps

module move_store
   (
      input  logic                              clk,
      input  logic                              reset,
      input  chess_pkg::board_t                 board,
      input  logic                              white_to_move,
      input  logic                              emit,
      input  logic                              start,
      input  logic [chess_pkg::SQ_IDX_W-1:0]    from_sq,
      input  logic [chess_pkg::SQ_IDX_W-1:0]    to_sq,
      input  logic [chess_pkg::MOVE_IDX_W-1:0]  move_index,
      output logic [chess_pkg::MOVE_CNT_W-1:0]  move_count,
      output chess_pkg::board_t                 board_out,
      output logic                              white_to_move_out,
      output logic                              capture_out
   );

   // record is capture, side to move, board
   logic [chess_pkg::BOARD_W+1:0] move_ram [chess_pkg::MAX_MOVES];
   logic [chess_pkg::BOARD_W+1:0] rd_data;
   chess_pkg::board_t             next_board;
   chess_pkg::board_t             wr_board;
   logic                          wr_en;
   logic                          wr_capture;
   logic                          wr_side;
   logic                          wr_ok;

   always_comb
   begin
      next_board = board;
      next_board[from_sq].code = {1'b0, chess_pkg::KIND_EMPTY};
      next_board[to_sq] = board[from_sq];
   end

   assign wr_ok = wr_en && move_count < chess_pkg::MAX_MOVES; // full RAM drops records

   always_ff @(posedge clk)
   begin
      if (reset)
         wr_en <= 1'b0;
      else
         wr_en <= emit;
   end

   always_ff @(posedge clk)
   begin
      if (emit)
      begin
         wr_board   <= next_board;
         wr_capture <= board[to_sq].code != '0;
         wr_side    <= !white_to_move;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || start)
         move_count <= '0;
      else if (wr_en)
         move_count <= move_count + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (wr_ok)
         move_ram[move_count[chess_pkg::MOVE_IDX_W-1:0]] <= {wr_capture, wr_side, wr_board};
      rd_data <= move_ram[move_index];
   end

   assign {capture_out, white_to_move_out} = rd_data[chess_pkg::BOARD_W+1:chess_pkg::BOARD_W];
   assign board_out = rd_data[chess_pkg::BOARD_W-1:0];

endmodule

//--- hw/move_gen.sv
`timescale 1ns/100ps

module move_gen
   (
      input  logic                              clk,
      input  logic                              reset,
      input  logic                              board_valid,
      input  chess_pkg::board_t                 board_in,
      input  logic                              white_to_move_in,
      input  logic [chess_pkg::MOVE_IDX_W-1:0]  move_index,
      input  logic                              clear_moves,
      output logic                              moves_ready,
      output logic [chess_pkg::MOVE_CNT_W-1:0]  move_count,
      output chess_pkg::board_t                 board_out,
      output logic                              white_to_move_out,
      output logic                              capture_out
   );

   logic [2:0]                          kind;
   logic [2:0]                          dir_index;
   logic signed [2:0]                   d_row;
   logic signed [2:0]                   d_col;
   logic [3:0]                          dir_count;
   logic                                is_slider;
   logic [2:0]                          origin_row;
   logic [2:0]                          origin_col;
   logic [3:0][chess_pkg::SQ_IDX_W-1:0] pawn_to;
   logic [3:0]                          pawn_ok;
   chess_pkg::board_t                   board;
   logic                                white_to_move;
   logic                                emit;
   logic                                start;
   logic [chess_pkg::SQ_IDX_W-1:0]      from_sq;
   logic [chess_pkg::SQ_IDX_W-1:0]      to_sq;

   square_walker square_walker_inst
      (
         .clk              (clk),
         .reset            (reset),
         .board_valid      (board_valid),
         .board_in         (board_in),
         .white_to_move_in (white_to_move_in),
         .clear_moves      (clear_moves),
         .kind             (kind),
         .dir_index        (dir_index),
         .d_row            (d_row),
         .d_col            (d_col),
         .dir_count        (dir_count),
         .is_slider        (is_slider),
         .origin_row       (origin_row),
         .origin_col       (origin_col),
         .pawn_to          (pawn_to),
         .pawn_ok          (pawn_ok),
         .board            (board),
         .white_to_move    (white_to_move),
         .emit             (emit),
         .start            (start),
         .from_sq          (from_sq),
         .to_sq            (to_sq),
         .moves_ready      (moves_ready)
      );

   step_table step_table_inst
      (
         .kind      (kind),
         .dir_index (dir_index),
         .d_row     (d_row),
         .d_col     (d_col),
         .dir_count (dir_count),
         .is_slider (is_slider)
      );

   pawn_targets pawn_targets_inst
      (
         .clk           (clk),
         .board         (board),
         .white_to_move (white_to_move),
         .origin_row    (origin_row),
         .origin_col    (origin_col),
         .pawn_to       (pawn_to),
         .pawn_ok       (pawn_ok)
      );

   move_store move_store_inst
      (
         .clk               (clk),
         .reset             (reset),
         .board             (board),
         .white_to_move     (white_to_move),
         .emit              (emit),
         .start             (start),
         .from_sq           (from_sq),
         .to_sq             (to_sq),
         .move_index        (move_index),
         .move_count        (move_count),
         .board_out         (board_out),
         .white_to_move_out (white_to_move_out),
         .capture_out       (capture_out)
      );

endmodule

//--- sim/move_gen_assert.sv
`timescale 1ns/100ps

module move_gen_assert
   (
      input logic                             clk,
      input logic                             reset,
      input logic                             clear_moves,
      input logic                             moves_ready,
      input logic [chess_pkg::MOVE_CNT_W-1:0] move_count
   );

   int assert_errors = 0; // failed assertions so far

   ready_low_in_reset: assert property (@(posedge clk) reset |=> !moves_ready)
      else
      begin
         $error("moves_ready high after a reset cycle");
         assert_errors++;
      end

   count_stable: assert property (@(posedge clk) disable iff (reset)
         moves_ready |=> !moves_ready || $stable(move_count))
      else
      begin
         $error("move_count changed while moves_ready was high");
         assert_errors++;
      end

   clear_drops_ready: assert property (@(posedge clk) disable iff (reset)
         moves_ready && clear_moves |=> !moves_ready)
      else
      begin
         $error("moves_ready still high one cycle after clear_moves");
         assert_errors++;
      end

   count_in_range: assert property (@(posedge clk) disable iff (reset)
         move_count <= chess_pkg::MAX_MOVES)
      else
      begin
         $error("move_count above the move RAM depth");
         assert_errors++;
      end

endmodule

bind move_gen move_gen_assert move_gen_assert_inst
   (
      .clk         (clk),
      .reset       (reset),
      .clear_moves (clear_moves),
      .moves_ready (moves_ready),
      .move_count  (move_count)
   );

//--- sim/move_gen_tb.sv
`timescale 1ns/100ps

module move_gen_tb;

   localparam int NUM_TESTS   = 7;
   localparam int REC_WORDS   = 11; // eight rows, side, moves, captures
   localparam int READY_LIMIT = 2000;

   logic                             clk = 1'b0;
   logic                             reset;
   logic                             board_valid;
   chess_pkg::board_t                board_in;
   logic                             white_to_move_in;
   logic [chess_pkg::MOVE_IDX_W-1:0] move_index;
   logic                             clear_moves;
   logic                             moves_ready;
   logic [chess_pkg::MOVE_CNT_W-1:0] move_count;
   chess_pkg::board_t                board_out;
   logic                             white_to_move_out;
   logic                             capture_out;

   logic [31:0]       golden_mem [NUM_TESTS*REC_WORDS];
   chess_pkg::board_t seen [chess_pkg::MAX_MOVES]; // records read so far in a test
   int                errors;
   int                test_errors;
   int                tests_run;

   move_gen move_gen_inst
      (
         .clk               (clk),
         .reset             (reset),
         .board_valid       (board_valid),
         .board_in          (board_in),
         .white_to_move_in  (white_to_move_in),
         .move_index        (move_index),
         .clear_moves       (clear_moves),
         .moves_ready       (moves_ready),
         .move_count        (move_count),
         .board_out         (board_out),
         .white_to_move_out (white_to_move_out),
         .capture_out       (capture_out)
      );

   always #2 clk = !clk; // 4 ns period

   task automatic compare_count(input logic [chess_pkg::MOVE_CNT_W-1:0] got,
                                input logic [chess_pkg::MOVE_CNT_W-1:0] exp,
                                input string what);
      if (got !== exp)
      begin
         $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   task automatic compare_board(input chess_pkg::board_t got,
                                input chess_pkg::board_t exp,
                                input string what);
      if (got !== exp)
      begin
         $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   task automatic compare_flag(input bit got, input bit exp, input string what);
      if (got !== exp)
      begin
         $display("FAILED at %0t: %s is %0b, expected %0b", $time, what, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   function automatic int count_pieces(input chess_pkg::board_t b);
      int cnt;
      cnt = 0;
      for (int s = 0; s < chess_pkg::NUM_SQUARES; s++)
         if (b[s].code != '0)
            cnt++;
      return cnt;
   endfunction

   task automatic wait_ready(output bit ready);
      int cycles;
      ready  = 1'b0;
      cycles = 0;
      while (!ready && cycles < READY_LIMIT)
      begin
         @(negedge clk);
         ready = moves_ready;
         cycles++;
      end
   endtask

   // one cycle read latency, sampled mid cycle
   task automatic read_record(input int idx);
      @(posedge clk);
      move_index <= idx[chess_pkg::MOVE_IDX_W-1:0];
      @(posedge clk);
      @(negedge clk);
   endtask

   task automatic run_test(input int t);
      chess_pkg::board_t                start_board;
      chess_pkg::board_t                rec;
      chess_pkg::board_t                expect_board;
      chess_pkg::square_u               mover;
      logic                             side;
      logic [chess_pkg::MOVE_CNT_W-1:0] exp_moves;
      logic [chess_pkg::MOVE_CNT_W-1:0] exp_caps;
      int                               order [chess_pkg::MAX_MOVES];
      int                               base, n, caps, j, tmp;
      int                               from_sq, to_sq, from_row, to_row;
      int                               diff_cnt, pieces_in, pieces_out;
      bit                               ready;
      bit                               dup;
      base = t * REC_WORDS;
      for (int r = 0; r < 8; r++)
         start_board[r*8 +: 8] = golden_mem[base + r];
      side        = golden_mem[base + 8][0];
      exp_moves   = golden_mem[base + 9][chess_pkg::MOVE_CNT_W-1:0];
      exp_caps    = golden_mem[base + 10][chess_pkg::MOVE_CNT_W-1:0];
      test_errors = 0;
      caps        = 0;
      pieces_in   = count_pieces(start_board);

      @(posedge clk);
      board_in         <= start_board;
      white_to_move_in <= side;
      board_valid      <= 1'b1;
      @(posedge clk);
      board_valid <= 1'b0;
      wait_ready(ready);
      if (!ready)
      begin
         $display("test %0d: moves_ready did not rise within %0d cycles", t, READY_LIMIT);
         errors++;
         return;
      end
      compare_count(move_count, exp_moves, "move count");
      n = move_count;

      for (int i = 0; i < n; i++)
         order[i] = i;
      for (int i = n - 1; i > 0; i--) // shuffled readback order
      begin
         j        = $urandom % (i + 1);
         tmp      = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end

      for (int k = 0; k < n; k++)
      begin
         read_record(order[k]);
         rec = board_out;
         compare_flag(moves_ready, 1'b1, "moves_ready during readback");
         compare_flag(white_to_move_out, !side, "side to move of record");
         diff_cnt = 0;
         from_sq  = -1;
         to_sq    = -1;
         for (int s = 0; s < chess_pkg::NUM_SQUARES; s++)
            if (rec[s].code != start_board[s].code)
            begin
               diff_cnt++;
               if (rec[s].code == '0)
                  from_sq = s;
               else
                  to_sq = s;
            end
         compare_count(diff_cnt, 2, "changed squares");
         compare_flag(from_sq >= 0 && to_sq >= 0, 1'b1, "one emptied and one filled square");
         pieces_out = count_pieces(rec);
         compare_flag(capture_out, pieces_in - pieces_out == 1, "capture flag");
         if (capture_out)
            caps++;
         if (from_sq >= 0 && to_sq >= 0)
         begin
            mover = start_board[from_sq];
            compare_flag(mover.code != '0 && mover.piece.black == !side, 1'b1, "mover color");
            expect_board          = start_board;
            expect_board[from_sq] = '0;
            expect_board[to_sq]   = mover;
            compare_board(rec, expect_board, "successor board");
            from_row = from_sq / 8;
            to_row   = to_sq / 8;
            if (mover.piece.kind == chess_pkg::KIND_PAWN)
            begin
               compare_flag(from_row == (side ? 6 : 1), 1'b0, "pawn moved from promotion row");
               if (to_row - from_row == 2 || from_row - to_row == 2)
               begin
                  compare_flag(from_row == (side ? 1 : 6), 1'b1, "double advance start row");
                  compare_flag(start_board[(from_sq + to_sq) / 2].code == '0 &&
                               start_board[to_sq].code == '0, 1'b1, "double advance path");
               end
            end
         end
         dup = 1'b0;
         for (int i = 0; i < k; i++)
            if (seen[i] == rec)
               dup = 1'b1;
         compare_flag(dup, 1'b0, "duplicate record");
         seen[k] = rec;
      end
      compare_count(caps, exp_caps, "capture count");

      // a new position while results are held must be ignored
      @(posedge clk);
      board_in         <= '0;
      white_to_move_in <= !side;
      board_valid      <= 1'b1;
      @(posedge clk);
      board_valid <= 1'b0;
      repeat (3) @(negedge clk);
      compare_count(move_count, n, "move count after busy board_valid");
      compare_flag(moves_ready, 1'b1, "moves_ready after busy board_valid");

      @(posedge clk);
      clear_moves <= 1'b1;
      @(negedge clk);
      compare_flag(moves_ready, 1'b1, "moves_ready before clear is taken");
      @(posedge clk);
      clear_moves <= 1'b0;
      @(negedge clk);
      compare_flag(moves_ready, 1'b0, "moves_ready one cycle after clear");
      $display("test %0d done: %0d moves, %0d captures, %0d mismatches",
               t, n, caps, test_errors);
   endtask

   initial
   begin
      errors           = 0;
      test_errors      = 0;
      tests_run        = 0;
      reset            = 1'b1;
      board_valid      = 1'b0;
      board_in         = '0;
      white_to_move_in = 1'b0;
      move_index       = '0;
      clear_moves      = 1'b0;
      void'($urandom(98));
      $readmemh("sim/move_gen_golden.txt", golden_mem);
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      compare_flag(moves_ready, 1'b0, "moves_ready after reset");
      for (int t = 0; t < NUM_TESTS; t++)
      begin
         run_test(t);
         tests_run++;
      end
      $display("tests run %0d, mismatches %0d, assertion failures %0d",
               tests_run, errors, move_gen_inst.move_gen_assert_inst.assert_errors);
      if (errors == 0 && move_gen_inst.move_gen_assert_inst.assert_errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

   // ends a hung run
   initial
   begin
      #(NUM_TESTS * READY_LIMIT * 4);
      $display("watchdog expired after %0d ns, run did not finish", NUM_TESTS * READY_LIMIT * 4);
      $display("Some tests failed");
      $finish;
   end

endmodule

//--- sim/move_gen_golden.txt
// eight row words from row 0 up, hex digits run from col 7 down to col 0,
// then side to move (1 = white), expected move count, expected capture count
// start position, white to move
42365324 11111111 00000000 00000000 00000000 00000000 99999999 CABEDBAC 1 14 0
// start position, black to move
42365324 11111111 00000000 00000000 00000000 00000000 99999999 CABEDBAC 0 14 0
// queen d4 with knight g1 and king a1, black rook d7 to take
02000006 00000000 00000000 00005000 00000000 00000000 0000C000 0000000E 1 1E 1
// black rook, king, knight and bishop against white rook h3 and pawn f2
00060000 00100000 40000000 00000000 00000B00 00000000 00000000 C00E00A0 0 19 2
// white pawns, blocked double advance, diagonal take, pawn on g7 skipped
60000000 00010101 009A0000 00000910 00000000 00000000 01000000 0000000E 1 8 1
// black pawns, same rules mirrored, pawn on b2 skipped
00000006 00000090 00000000 03000000 00900000 00021000 00009009 E0000000 0 8 2
// rook and bishop blocked by own pieces, bishop takes rook h6
00060304 00000000 00000000 00000000 00000000 C0000000 00000000 E0000000 1 14 1

//--- move_gen.f
hw/chess_pkg.sv
hw/step_table.sv
hw/pawn_targets.sv
hw/square_walker.sv
hw/move_store.sv
hw/move_gen.sv
sim/move_gen_assert.sv
sim/move_gen_tb.sv

//--- Bender.yml
package:
  name: move_gen

sources:
  - files:
      - hw/chess_pkg.sv
      - hw/step_table.sv
      - hw/pawn_targets.sv
      - hw/square_walker.sv
      - hw/move_store.sv
      - hw/move_gen.sv
  - target: simulation
    files:
      - sim/move_gen_assert.sv
      - sim/move_gen_tb.sv
